// File: hw/pipePkg.sv
`default_nettype none

package pipePkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int regCount = 2 ** regAddrWidth;
	localparam int ramAddrWidth = 4;
	localparam int ramDepth = 16;

	localparam int opMsb = 31;
	localparam int opLsb = 26;
	localparam int rsMsb = 25;
	localparam int rsLsb = 21;
	localparam int rtMsb = 20;
	localparam int rtLsb = 16;
	localparam int rdMsb = 15;
	localparam int rdLsb = 11;
	localparam int immMsb = 15;
	localparam int immLsb = 0;

	localparam logic [dataWidth-1:0] nopInstr = '0;

	typedef enum logic [5:0] {
		opNop = 6'd0,
		opAdd,
		opSub,
		opAnd,
		opOr,
		opAddi,
		opLw,
		opSw,
		opBeq
	} opcodeT;

	typedef enum logic [1:0] {
		fwdNone = 2'd0,
		fwdMem,
		fwdWb
	} fwdSelT;

endpackage

`default_nettype wire

// File: hw/fetchPort.sv
`default_nettype none
`timescale 1ns/1ps

module fetchPort (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          fetchAck,
	input  logic [pipePkg::dataWidth-1:0] fetchInstr,
	input  logic                          freezeFront,
	input  logic                          freezeAll,
	input  logic                          brTaken,
	input  logic [pipePkg::dataWidth-1:0] brTarget,
	output logic                          fetchReq,
	output logic [pipePkg::dataWidth-1:0] fetchAddr,
	output logic [pipePkg::dataWidth-1:0] idInstr,
	output logic [pipePkg::dataWidth-1:0] idPc,
	output logic                          fetchWait
);
	import pipePkg::*;

	logic advance;
	logic capture;
	logic takeNow;
	logic brPend;
	logic [dataWidth-1:0] brPendTarget;

	assign advance = !freezeFront && !freezeAll;
	assign capture = fetchReq && fetchAck && advance;
	assign takeNow = brTaken && advance; // Branch leaves decode
	assign fetchWait = !(fetchReq && fetchAck);

	always_ff @(posedge clk) begin
		if (!rst) begin
			fetchReq <= 1'b0;
			fetchAddr <= '0;
			brPend <= 1'b0;
			idInstr <= nopInstr;
		end else begin
			if (capture) begin
				fetchReq <= 1'b0;
				brPend <= 1'b0;
				// Delay slot is being captured, so redirect what follows it
				if (brPend)
					fetchAddr <= brPendTarget;
				else if (takeNow)
					fetchAddr <= brTarget;
				else
					fetchAddr <= fetchAddr + dataWidth'(4);
			end else begin
				if (!fetchReq && !fetchAck)
					fetchReq <= 1'b1; // New phase once ack is low
				if (takeNow)
					brPend <= 1'b1;
			end
			if (capture)
				idInstr <= fetchInstr;
			else if (advance)
				idInstr <= nopInstr; // Bubble while waiting
		end
	end

	always_ff @(posedge clk) begin
		if (capture)
			idPc <= fetchAddr;
		if (takeNow)
			brPendTarget <= brTarget;
	end

	assert property (@(posedge clk) disable iff (!rst)
		fetchReq |=> !fetchReq || $stable(fetchAddr));

endmodule

`default_nettype wire

// File: hw/decodeStage.sv
`default_nettype none
`timescale 1ns/1ps

module decodeStage (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [pipePkg::dataWidth-1:0]    idInstr,
	input  logic [pipePkg::dataWidth-1:0]    idPc,
	input  logic                             wbWe,
	input  logic [pipePkg::regAddrWidth-1:0] wbReg,
	input  logic [pipePkg::dataWidth-1:0]    wbData,
	input  logic [pipePkg::dataWidth-1:0]    memResult,
	input  logic                             brFwdA,
	input  logic                             brFwdB,
	input  logic                             bubble,
	input  logic                             freezeAll,
	output logic                             brTaken,
	output logic [pipePkg::dataWidth-1:0]    brTarget,
	output logic [pipePkg::regAddrWidth-1:0] idRs,
	output logic [pipePkg::regAddrWidth-1:0] idRt,
	output logic                             isBranch,
	output pipePkg::opcodeT                  exOp,
	output logic [pipePkg::regAddrWidth-1:0] exRs,
	output logic [pipePkg::regAddrWidth-1:0] exRt,
	output logic [pipePkg::regAddrWidth-1:0] exDest,
	output logic [pipePkg::dataWidth-1:0]    exA,
	output logic [pipePkg::dataWidth-1:0]    exB,
	output logic [pipePkg::dataWidth-1:0]    exImm
);
	import pipePkg::*;

	logic [dataWidth-1:0] regFile [regCount];
	logic [opMsb-opLsb:0] rawOp;
	opcodeT idOp;
	logic [regAddrWidth-1:0] idRd;
	logic [regAddrWidth-1:0] idDest;
	logic [dataWidth-1:0] idImm;
	logic [dataWidth-1:0] rfA;
	logic [dataWidth-1:0] rfB;
	logic [dataWidth-1:0] brA;
	logic [dataWidth-1:0] brB;

	assign rawOp = idInstr[opMsb:opLsb];
	assign idOp = (rawOp <= opBeq) ? opcodeT'(rawOp) : opNop; // Unknown acts as NOP
	assign idRs = idInstr[rsMsb:rsLsb];
	assign idRt = idInstr[rtMsb:rtLsb];
	assign idRd = idInstr[rdMsb:rdLsb];
	assign idImm = {{(dataWidth - immMsb - 1){idInstr[immMsb]}}, idInstr[immMsb:immLsb]};
	assign isBranch = idOp == opBeq;

	always_comb begin
		case (idOp)
			opAdd, opSub, opAnd, opOr: idDest = idRd;
			opAddi, opLw: idDest = idRt;
			default: idDest = '0;
		endcase
	end

	// Write-first reads
	assign rfA = (idRs == '0) ? '0 : (wbWe && wbReg == idRs) ? wbData : regFile[idRs];
	assign rfB = (idRt == '0) ? '0 : (wbWe && wbReg == idRt) ? wbData : regFile[idRt];

	assign brA = brFwdA ? memResult : rfA;
	assign brB = brFwdB ? memResult : rfB;
	assign brTaken = isBranch && (brA == brB);
	assign brTarget = idPc + dataWidth'(4) + (idImm << 2); // Relative to delay slot

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < regCount; i++)
				regFile[i] <= '0;
		end else if (wbWe) begin
			regFile[wbReg] <= wbData;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			exOp <= opNop;
			exRs <= '0;
			exRt <= '0;
			exDest <= '0;
		end else if (!freezeAll) begin
			if (bubble) begin
				exOp <= opNop;
				exRs <= '0;
				exRt <= '0;
				exDest <= '0;
			end else begin
				exOp <= idOp;
				exRs <= idRs;
				exRt <= idRt;
				exDest <= idDest;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!freezeAll) begin
			exA <= rfA;
			exB <= rfB;
			exImm <= idImm;
		end
	end

endmodule

`default_nettype wire

// File: hw/bypassUnit.sv
`default_nettype none
`timescale 1ns/1ps

module bypassUnit (
	input  logic [pipePkg::regAddrWidth-1:0] exRs,
	input  logic [pipePkg::regAddrWidth-1:0] exRt,
	input  logic [pipePkg::regAddrWidth-1:0] idRs,
	input  logic [pipePkg::regAddrWidth-1:0] idRt,
	input  logic                             isBranch,
	input  logic                             memWe,
	input  logic [pipePkg::regAddrWidth-1:0] memDest,
	input  logic                             wbWe,
	input  logic [pipePkg::regAddrWidth-1:0] wbDest,
	output pipePkg::fwdSelT                  fwdA,
	output pipePkg::fwdSelT                  fwdB,
	output logic                             brFwdA,
	output logic                             brFwdB
);
	import pipePkg::*;

	logic memLive;
	logic wbLive;

	assign memLive = memWe && memDest != '0;
	assign wbLive = wbWe && wbDest != '0;

	// Memory stage is younger, so it wins
	assign fwdA = (memLive && memDest == exRs) ? fwdMem :
		(wbLive && wbDest == exRs) ? fwdWb : fwdNone;
	assign fwdB = (memLive && memDest == exRt) ? fwdMem :
		(wbLive && wbDest == exRt) ? fwdWb : fwdNone;

	// Loads in memory are stalled instead
	assign brFwdA = isBranch && memLive && memDest == idRs;
	assign brFwdB = isBranch && memLive && memDest == idRt;

endmodule

`default_nettype wire

// File: hw/stallUnit.sv
`default_nettype none
`timescale 1ns/1ps

module stallUnit (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [pipePkg::regAddrWidth-1:0] idRs,
	input  logic [pipePkg::regAddrWidth-1:0] idRt,
	input  logic                             isBranch,
	input  pipePkg::opcodeT                  exOp,
	input  logic [pipePkg::regAddrWidth-1:0] exDest,
	input  logic                             memIsLoad,
	input  logic [pipePkg::regAddrWidth-1:0] memDest,
	input  logic                             fetchWait,
	input  logic                             wbWe,
	input  logic                             retireFull,
	output logic                             freezeFront,
	output logic                             bubble,
	output logic                             freezeAll
);
	import pipePkg::*;

	typedef enum logic {retireFree, retireBusy} retireStateT;

	retireStateT state;
	retireStateT nextState;
	logic exMatch;
	logic memMatch;
	logic loadUse;
	logic brExHazard;
	logic brLoadHazard;
	logic hazard;

	assign exMatch = exDest != '0 && (exDest == idRs || exDest == idRt);
	assign memMatch = memDest != '0 && (memDest == idRs || memDest == idRt);
	assign loadUse = exOp == opLw && exMatch;
	assign brExHazard = isBranch && exMatch; // Result not computed yet
	assign brLoadHazard = isBranch && memIsLoad && memMatch;
	assign hazard = loadUse || brExHazard || brLoadHazard;

	always_ff @(posedge clk) begin
		if (!rst)
			state <= retireFree;
		else
			state <= nextState;
	end

	always_comb begin
		case (state)
			retireFree: nextState = (wbWe && retireFull) ? retireBusy : retireFree;
			retireBusy: nextState = retireFull ? retireBusy : retireFree;
			default: nextState = retireFree;
		endcase
	end

	assign freezeAll = retireFull && (state == retireBusy || wbWe);
	assign freezeFront = hazard;
	assign bubble = hazard && !freezeAll;

	assert property (@(posedge clk) disable iff (!rst)
		freezeAll |-> !bubble);

	// NOP from a missed fetch never stalls on r0
	assert property (@(posedge clk) disable iff (!rst)
		fetchWait && !freezeFront && !freezeAll |=> !freezeFront);

endmodule

`default_nettype wire

// File: hw/executeMemory.sv
`default_nettype none
`timescale 1ns/1ps

module executeMemory (
	input  logic                             clk,
	input  logic                             rst,
	input  pipePkg::opcodeT                  exOp,
	input  logic [pipePkg::regAddrWidth-1:0] exDest,
	input  logic [pipePkg::dataWidth-1:0]    exA,
	input  logic [pipePkg::dataWidth-1:0]    exB,
	input  logic [pipePkg::dataWidth-1:0]    exImm,
	input  pipePkg::fwdSelT                  fwdA,
	input  pipePkg::fwdSelT                  fwdB,
	input  logic                             freezeAll,
	output logic                             memWe,
	output logic [pipePkg::regAddrWidth-1:0] memDest,
	output logic [pipePkg::dataWidth-1:0]    memResult,
	output logic                             memIsLoad,
	output logic                             wbWe,
	output logic [pipePkg::regAddrWidth-1:0] wbReg,
	output logic [pipePkg::dataWidth-1:0]    wbData
);
	import pipePkg::*;

	logic [dataWidth-1:0] dataRam [ramDepth];
	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] opB;
	logic [dataWidth-1:0] aluOut;
	opcodeT memOp;
	logic [dataWidth-1:0] memAlu;
	logic [dataWidth-1:0] memStore;
	logic [ramAddrWidth-1:0] ramAddr;

	assign opA = (fwdA == fwdMem) ? memResult : (fwdA == fwdWb) ? wbData : exA;
	assign opB = (fwdB == fwdMem) ? memResult : (fwdB == fwdWb) ? wbData : exB;

	always_comb begin
		case (exOp)
			opAdd: aluOut = opA + opB;
			opSub: aluOut = opA - opB;
			opAnd: aluOut = opA & opB;
			opOr: aluOut = opA | opB;
			opAddi, opLw, opSw: aluOut = opA + exImm; // Also the RAM address
			default: aluOut = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			memOp <= opNop;
			memWe <= 1'b0;
			memDest <= '0;
		end else if (!freezeAll) begin
			memOp <= exOp;
			memWe <= exDest != '0; // Only writers carry a dest
			memDest <= exDest;
		end
	end

	always_ff @(posedge clk) begin
		if (!freezeAll) begin
			memAlu <= aluOut;
			memStore <= opB;
		end
	end

	assign ramAddr = memAlu[ramAddrWidth-1:0]; // Word index
	assign memIsLoad = memOp == opLw;
	assign memResult = memIsLoad ? dataRam[ramAddr] : memAlu;

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < ramDepth; i++)
				dataRam[i] <= '0;
		end else if (memOp == opSw && !freezeAll) begin
			dataRam[ramAddr] <= memStore;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst)
			wbWe <= 1'b0;
		else if (!freezeAll)
			wbWe <= memWe;
	end

	always_ff @(posedge clk) begin
		if (!freezeAll) begin
			wbReg <= memDest;
			wbData <= memResult;
		end
	end

endmodule

`default_nettype wire

// File: hw/retirePort.sv
`default_nettype none
`timescale 1ns/1ps

module retirePort (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             wbWe,
	input  logic [pipePkg::regAddrWidth-1:0] wbReg,
	input  logic [pipePkg::dataWidth-1:0]    wbData,
	input  logic                             retireAck,
	output logic                             retireReq,
	output logic [pipePkg::regAddrWidth-1:0] retireReg,
	output logic [pipePkg::dataWidth-1:0]    retireData,
	output logic                             retireFull
);
	import pipePkg::*;

	typedef enum logic {retireIdle, retireWaitAck} phaseT;

	phaseT phase;
	logic full;
	logic accept;

	assign accept = wbWe && !full;
	assign retireFull = full;
	assign retireReq = phase == retireWaitAck;

	always_ff @(posedge clk) begin
		if (!rst) begin
			phase <= retireIdle;
			full <= 1'b0;
		end else begin
			case (phase)
				retireIdle:
					if ((full || accept) && !retireAck)
						phase <= retireWaitAck; // Previous ack must be gone
				retireWaitAck:
					if (retireAck)
						phase <= retireIdle;
				default: phase <= retireIdle;
			endcase
			if (accept)
				full <= 1'b1;
			else if (phase == retireWaitAck && retireAck)
				full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			retireReg <= wbReg;
			retireData <= wbData;
		end
	end

	assert property (@(posedge clk) disable iff (!rst)
		retireReq |=> !retireReq || ($stable(retireReg) && $stable(retireData)));

endmodule

`default_nettype wire

// File: hw/pipeCore.sv
`default_nettype none
`timescale 1ns/1ps

module pipeCore (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             fetchAck,
	input  logic [pipePkg::dataWidth-1:0]    fetchInstr,
	input  logic                             retireAck,
	output logic                             fetchReq,
	output logic [pipePkg::dataWidth-1:0]    fetchAddr,
	output logic                             retireReq,
	output logic [pipePkg::regAddrWidth-1:0] retireReg,
	output logic [pipePkg::dataWidth-1:0]    retireData
);
	import pipePkg::*;

	logic [dataWidth-1:0] idInstr;
	logic [dataWidth-1:0] idPc;
	logic fetchWait;
	logic freezeFront;
	logic freezeAll;
	logic bubble;
	logic brTaken;
	logic [dataWidth-1:0] brTarget;
	logic [regAddrWidth-1:0] idRs;
	logic [regAddrWidth-1:0] idRt;
	logic isBranch;
	opcodeT exOp;
	logic [regAddrWidth-1:0] exRs;
	logic [regAddrWidth-1:0] exRt;
	logic [regAddrWidth-1:0] exDest;
	logic [dataWidth-1:0] exA;
	logic [dataWidth-1:0] exB;
	logic [dataWidth-1:0] exImm;
	logic brFwdA;
	logic brFwdB;
	fwdSelT fwdA;
	fwdSelT fwdB;
	logic memWe;
	logic [regAddrWidth-1:0] memDest;
	logic [dataWidth-1:0] memResult;
	logic memIsLoad;
	logic wbWe;
	logic [regAddrWidth-1:0] wbReg;
	logic [dataWidth-1:0] wbData;
	logic retireFull;

	fetchPort fetchPort_inst (
		.clk, .rst, .fetchAck, .fetchInstr, .freezeFront, .freezeAll,
		.brTaken, .brTarget, .fetchReq, .fetchAddr, .idInstr, .idPc, .fetchWait
	);

	decodeStage decodeStage_inst (
		.clk, .rst, .idInstr, .idPc, .wbWe, .wbReg, .wbData, .memResult,
		.brFwdA, .brFwdB, .bubble, .freezeAll, .brTaken, .brTarget, .idRs, .idRt,
		.isBranch, .exOp, .exRs, .exRt, .exDest, .exA, .exB, .exImm
	);

	bypassUnit bypassUnit_inst (
		.exRs, .exRt, .idRs, .idRt, .isBranch, .memWe, .memDest, .wbWe,
		.wbDest(wbReg), .fwdA, .fwdB, .brFwdA, .brFwdB
	);

	stallUnit stallUnit_inst (
		.clk, .rst, .idRs, .idRt, .isBranch, .exOp, .exDest, .memIsLoad, .memDest,
		.fetchWait, .wbWe, .retireFull, .freezeFront, .bubble, .freezeAll
	);

	executeMemory executeMemory_inst (
		.clk, .rst, .exOp, .exDest, .exA, .exB, .exImm, .fwdA, .fwdB, .freezeAll,
		.memWe, .memDest, .memResult, .memIsLoad, .wbWe, .wbReg, .wbData
	);

	retirePort retirePort_inst (
		.clk, .rst, .wbWe, .wbReg, .wbData, .retireAck,
		.retireReq, .retireReg, .retireData, .retireFull
	);

endmodule

`default_nettype wire

// File: verif/refModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

localparam int progLen = 200;
localparam int tailNops = 8;
localparam int regSpan = 8; // r0 to r7, dense hazards

logic [31:0] prog [progLen];
logic [31:0] expAddr [$];
logic [4:0] expReg [$];
logic [31:0] expData [$];

function automatic logic [31:0] encodeR(opcodeT op, logic [4:0] rd, logic [4:0] rs,
	logic [4:0] rt);
	return {op, rs, rt, rd, 11'd0};
endfunction

function automatic logic [31:0] encodeI(opcodeT op, logic [4:0] rt, logic [4:0] rs,
	logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

task automatic genProgram();
	int kind;
	logic [4:0] rd;
	logic [4:0] rs;
	logic [4:0] rt;
	bit lastBranch;
	lastBranch = 1'b0;
	for (int i = 0; i < progLen; i++) begin
		kind = $urandom_range(0, 9);
		rd = 5'($urandom_range(0, regSpan - 1));
		rs = 5'($urandom_range(0, regSpan - 1));
		rt = 5'($urandom_range(0, regSpan - 1));
		// No branch in a delay slot, none close to the tail
		if (kind == 8 && (lastBranch || i >= progLen - tailNops - 2))
			kind = 4;
		lastBranch = kind == 8;
		if (i >= progLen - tailNops) begin
			prog[i] = nopInstr;
		end else begin
			case (kind)
				0: prog[i] = encodeR(opAdd, rd, rs, rt);
				1: prog[i] = encodeR(opSub, rd, rs, rt);
				2: prog[i] = encodeR(opAnd, rd, rs, rt);
				3: prog[i] = encodeR(opOr, rd, rs, rt);
				4, 5: prog[i] = encodeI(opAddi, rt, rs, 16'($urandom_range(0, 15)) - 16'd8);
				6: prog[i] = encodeI(opLw, rt, rs, 16'($urandom_range(0, 15)));
				7: prog[i] = encodeI(opSw, rt, rs, 16'($urandom_range(0, 15)));
				8: begin
					if ($urandom_range(0, 2) == 0)
						rt = rs; // Always taken
					prog[i] = encodeI(opBeq, rt, rs, 16'($urandom_range(1, 6)));
				end
				default: prog[i] = nopInstr;
			endcase
		end
	end
endtask

task automatic runModel();
	logic [31:0] regs [32];
	logic [31:0] ram [16];
	logic [31:0] instr;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] simm;
	logic [31:0] res;
	logic [5:0] op;
	logic [4:0] dest;
	logic [3:0] idx;
	int pc;
	int nextPc;
	int pendTarget;
	bit pend;
	foreach (regs[i])
		regs[i] = '0;
	foreach (ram[i])
		ram[i] = '0;
	pc = 0;
	pend = 1'b0;
	pendTarget = 0;
	while (pc < progLen) begin
		instr = prog[pc];
		op = instr[31:26];
		a = regs[instr[25:21]];
		b = regs[instr[20:16]];
		simm = {{16{instr[15]}}, instr[15:0]};
		idx = 4'(a + simm); // Word index in data RAM
		dest = '0;
		res = '0;
		expAddr.push_back(32'(pc * 4));
		nextPc = pend ? pendTarget : pc + 1; // Redirect after the delay slot
		pend = 1'b0;
		case (op)
			opAdd: begin res = a + b; dest = instr[15:11]; end
			opSub: begin res = a - b; dest = instr[15:11]; end
			opAnd: begin res = a & b; dest = instr[15:11]; end
			opOr: begin res = a | b; dest = instr[15:11]; end
			opAddi: begin res = a + simm; dest = instr[20:16]; end
			opLw: begin res = ram[idx]; dest = instr[20:16]; end
			opSw: ram[idx] = b;
			opBeq: begin
				if (a == b) begin
					pend = 1'b1;
					pendTarget = pc + 1 + int'($signed(instr[15:0]));
				end
			end
			default: ;
		endcase
		if (dest != '0) begin // r0 writes never retire
			regs[dest] = res;
			expReg.push_back(dest);
			expData.push_back(res);
		end
		pc = nextPc;
	end
endtask

`endif

// File: verif/coreTb.sv
`default_nettype none
`timescale 1ns/1ps

module coreTb;
	import pipePkg::*;

	localparam int cyclesPerRecord = 200;
	localparam int drainCycles = 100;

	logic clk;
	logic rst;
	logic fetchAck;
	logic [31:0] fetchInstr;
	logic retireAck;
	logic fetchReq;
	logic [31:0] fetchAddr;
	logic retireReq;
	logic [4:0] retireReg;
	logic [31:0] retireData;
	bit modelReady;
	int timeoutCycles;

	`include "refModel.svh"

	pipeCore pipeCore_inst (
		.clk, .rst, .fetchAck, .fetchInstr, .retireAck,
		.fetchReq, .fetchAddr, .retireReq, .retireReg, .retireData
	);

	task automatic reportFailure(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			reportFailure($sformatf("Error: %s is 0x%h, expected 0x%h", name, actual, expected));
	endtask

	function automatic logic [31:0] instrAt(logic [31:0] addr);
		int idx;
		idx = int'(addr >> 2);
		if (idx < progLen)
			return prog[idx];
		return nopInstr; // Past the end of the program
	endfunction

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		rst = 1'b0;
		fetchAck = 1'b0;
		fetchInstr = nopInstr;
		retireAck = 1'b0;
		modelReady = 1'b0;
		void'($urandom(32'h219e));
		genProgram();
		runModel();
		timeoutCycles = (expReg.size() + 1) * cyclesPerRecord;
		modelReady = 1'b1;
		repeat (16) @(negedge clk);
		rst = 1'b1;
		while (expReg.size() != 0)
			@(negedge clk);
		repeat (drainCycles) @(negedge clk); // Catch extra records
		if (expAddr.size() != 0) begin
			reportFailure("Not every expected fetch address was requested by the core");
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

	// Instruction source
	initial begin
		logic [31:0] addr;
		int delay;
		wait (rst === 1'b1);
		forever begin
			@(negedge clk);
			if (fetchReq) begin
				addr = fetchAddr;
				if (expAddr.size() != 0)
					checkValue("fetchAddr", addr, expAddr.pop_front());
				delay = $urandom_range(0, 3);
				repeat (delay) @(negedge clk);
				fetchInstr = instrAt(addr);
				fetchAck = 1'b1;
				@(negedge clk);
				while (fetchReq)
					@(negedge clk);
				fetchAck = 1'b0;
			end
		end
	end

	// Retire sink
	initial begin
		logic [4:0] wantReg;
		logic [31:0] wantData;
		int delay;
		wait (rst === 1'b1);
		forever begin
			@(negedge clk);
			if (retireReq) begin
				if (expReg.size() == 0) begin
					reportFailure("A retire record arrived after the last expected one");
				end else begin
					wantReg = expReg.pop_front();
					wantData = expData.pop_front();
					checkValue("retireReg", retireReg, wantReg);
					checkValue("retireData", retireData, wantData);
					delay = $urandom_range(0, 5);
					repeat (delay) @(negedge clk);
					retireAck = 1'b1;
					@(negedge clk);
					while (retireReq)
						@(negedge clk);
					retireAck = 1'b0;
				end
			end
		end
	end

	initial begin
		wait (modelReady);
		repeat (timeoutCycles) @(posedge clk);
		reportFailure($sformatf("Timeout: the core did not retire all expected records in %0d cycles",
			timeoutCycles));
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+verif
hw/pipePkg.sv
hw/fetchPort.sv
hw/decodeStage.sv
hw/bypassUnit.sv
hw/stallUnit.sv
hw/executeMemory.sv
hw/retirePort.sv
hw/pipeCore.sv
verif/coreTb.sv
